// File: src.f
+incdir+logic
logic/karatsuba_pkg.sv
logic/karatsuba_ctrl_if.sv
logic/mult_lut.sv
logic/cla_adder.sv
logic/karatsuba_dp.sv
logic/karatsuba_ctrl.sv
logic/karatsuba_mult.sv
test/karatsuba_tb.sv

// File: Makefile
# Verilator build and run for the Karatsuba multiplier testbench.

TOP := karatsuba_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee run.log
	@grep -q "TESTBENCH PASSED" run.log

clean:
	rm -rf $(OBJ) run.log

// File: test/karatsuba_tb.sv
`include "karatsuba_settings.svh"

module karatsuba_tb;

  localparam int DoneLat    = 11;  // done cycle, counted from the start edge.
  localparam int NumRandom  = 300;
  localparam int NumCorner  = 6;
  localparam int NumBusy    = 1;
  localparam int NumBurst   = 4;
  localparam int NumOps     = NumRandom + NumCorner + NumBusy + NumBurst;
  localparam int OpCycles   = 20;
  localparam int TimeoutCyc = OpCycles * NumOps + 50;

  logic                  clk;
  logic                  reset;
  logic                  start;
  logic [`KM_OP_W-1:0]   a;
  logic [`KM_OP_W-1:0]   b;
  logic                  busy;
  logic                  done;
  logic [`KM_PROD_W-1:0] product;

  logic [31:0]           rng_state;
  logic [`KM_PROD_W-1:0] last_expected;
  int                    product_errors;
  int                    flag_errors;
  int                    cycle_count;

  karatsuba_mult u_dut (
    .clk_i     (clk),
    .reset_i   (reset),
    .start_i   (start),
    .a_i       (a),
    .b_i       (b),
    .busy_o    (busy),
    .done_o    (done),
    .product_o (product)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------
  // model and random source
  // --------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [`KM_PROD_W-1:0] product_model(input logic [`KM_OP_W-1:0] x,
                                                         input logic [`KM_OP_W-1:0] y);
    return `KM_PROD_W'(x) * `KM_PROD_W'(y);
  endfunction

  task automatic next_operand(output logic [`KM_OP_W-1:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state[`KM_OP_W-1:0];
  endtask

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_product(input logic [`KM_PROD_W-1:0] got,
                               input logic [`KM_PROD_W-1:0] exp,
                               input string what);
    if (got !== exp) begin
      product_errors++;
      $display("[FAIL] %0t: %s product_o = %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errors++;
      $display("[FAIL] %0t: %s = %b, expected %b", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------
  // operations
  // --------------------------------------------------
  // one multiply, next start comes right after done.
  task automatic run_op(input logic [`KM_OP_W-1:0] op_a, input logic [`KM_OP_W-1:0] op_b,
                        input logic interfere);
    logic [`KM_PROD_W-1:0] exp;
    logic [`KM_OP_W-1:0]   junk;
    string                 tag;
    exp = product_model(op_a, op_b);
    tag = $sformatf("%0d x %0d", op_a, op_b);
    @(posedge clk);
    #1;
    start = 1'b1;
    a     = op_a;
    b     = op_b;
    @(posedge clk);  // start edge.
    for (int k = 1; k <= DoneLat; k++) begin
      if (k > 1) begin
        @(posedge clk);
      end
      #1;
      start = interfere && (k >= 3) && (k <= 5);  // must be ignored.
      next_operand(junk);
      a = junk;
      next_operand(junk);
      b = junk;
      @(negedge clk);
      check_flag(busy, 1'b1, $sformatf("%s cycle %0d busy_o", tag, k));
      check_flag(done, k == DoneLat, $sformatf("%s cycle %0d done_o", tag, k));
    end
    check_product(product, exp, tag);
    last_expected = exp;
  endtask

  task automatic idle_cycles(input int n, input logic hold);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #1;
      start = 1'b0;
      @(negedge clk);
      check_flag(busy, 1'b0, "idle busy_o");
      check_flag(done, 1'b0, "idle done_o");
      if (hold) begin
        check_product(product, last_expected, "held");
      end
    end
  endtask

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------
  initial begin
    cycle_count = 0;
    while (cycle_count < TimeoutCyc) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TimeoutCyc);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    logic [`KM_OP_W-1:0] op_a;
    logic [`KM_OP_W-1:0] op_b;
    reset          = 1'b1;
    start          = 1'b0;
    a              = '0;
    b              = '0;
    rng_state      = 32'h5ec4;
    last_expected  = '0;
    product_errors = 0;
    flag_errors    = 0;

    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    idle_cycles(3, 1'b0);

    for (int i = 0; i < NumRandom; i++) begin
      next_operand(op_a);
      next_operand(op_b);
      run_op(op_a, op_b, 1'b0);
    end
    idle_cycles(4, 1'b1);

    // corners, 1023 gives half-sums of 62.
    run_op(10'd0, 10'd0, 1'b0);
    run_op(10'd1, 10'd1, 1'b0);
    run_op(10'd1023, 10'd1023, 1'b0);
    run_op(10'd0, 10'd1023, 1'b0);
    run_op(10'd1023, 10'd1, 1'b0);
    run_op(10'd1, 10'd1023, 1'b0);
    idle_cycles(3, 1'b1);

    run_op(10'd717, 10'd298, 1'b1);
    idle_cycles(3, 1'b1);  // no second done.

    for (int i = 0; i < NumBurst; i++) begin
      next_operand(op_a);
      next_operand(op_b);
      run_op(op_a, op_b, 1'b0);
    end
    idle_cycles(5, 1'b1);

    $display("errors: %0d product, %0d flag, %0d total", product_errors, flag_errors,
             product_errors + flag_errors);
    if (product_errors + flag_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: logic/karatsuba_mult.sv
`include "karatsuba_settings.svh"

module karatsuba_mult (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  start_i,
  input  logic [`KM_OP_W-1:0]   a_i,
  input  logic [`KM_OP_W-1:0]   b_i,
  output logic                  busy_o,
  output logic                  done_o,
  output logic [`KM_PROD_W-1:0] product_o
);

  karatsuba_ctrl_if u_ctrl_if ();

  // --------------------------------------------------
  // controller and datapath
  // --------------------------------------------------
  karatsuba_ctrl u_ctrl (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .start_i (start_i),
    .ctrl    (u_ctrl_if.ctrl),
    .busy_o  (busy_o),
    .done_o  (done_o)
  );

  karatsuba_dp u_dp (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .a_i       (a_i),
    .b_i       (b_i),
    .ctrl      (u_ctrl_if.dp),
    .product_o (product_o)
  );

endmodule

// File: logic/karatsuba_ctrl.sv
module karatsuba_ctrl
  import karatsuba_pkg::*;
(
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           start_i,
  karatsuba_ctrl_if.ctrl ctrl,
  output logic           busy_o,
  output logic           done_o
);

  km_step_e step_q;
  km_step_e step_d;

  // --------------------------------------------------
  // sequencer
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      step_q <= IDLE;
    end else begin
      step_q <= step_d;
    end
  end

  always_comb begin
    case (step_q)
      IDLE:    step_d = start_i ? LOAD : IDLE;
      LOAD:    step_d = SUM_A;
      SUM_A:   step_d = MUL_HI;
      MUL_HI:  step_d = MUL_LO;
      MUL_LO:  step_d = SUM_B;
      SUM_B:   step_d = MUL_MID;
      MUL_MID: step_d = SUB_HI;
      SUB_HI:  step_d = SUB_LO;
      SUB_LO:  step_d = ADD_HI;
      ADD_HI:  step_d = ADD_MID;
      ADD_MID: step_d = FINISH;
      default: step_d = IDLE;
    endcase
  end

  assign busy_o = (step_q != IDLE);
  assign done_o = (step_q == FINISH);

  // --------------------------------------------------
  // step decode
  // --------------------------------------------------
  always_comb begin
    ctrl.load_reg1      = 1'b0;
    ctrl.load_reg2      = 1'b0;
    ctrl.load_reg3      = 1'b0;
    ctrl.load_reg4      = 1'b0;
    ctrl.sel_reg1       = 1'b0;
    ctrl.sel_reg2       = 1'b0;
    ctrl.sel_reg3       = 1'b0;
    ctrl.sel_reg4       = 1'b0;
    ctrl.alu_a_sel      = HALF_A;
    ctrl.alu_b_sel      = HALF_A;
    ctrl.alu_b_wide_sel = 1'b0;
    ctrl.mult_x_sel     = LO_HALF;
    ctrl.mult_y_sel     = LO_HALF;
    ctrl.shamt          = NONE;
    ctrl.sub            = 1'b0;

    case (step_q)
      IDLE: begin
        ctrl.load_reg1 = start_i;  // capture a and b.
        ctrl.load_reg2 = start_i;
      end
      SUM_A: begin  // reg4 = a_h + a_l.
        ctrl.load_reg4 = 1'b1;
        ctrl.sel_reg4  = 1'b1;
      end
      MUL_HI: begin  // reg3 = a_h * b_h.
        ctrl.mult_x_sel = HI_HALF;
        ctrl.mult_y_sel = HI_HALF;
        ctrl.load_reg3  = 1'b1;
      end
      MUL_LO: begin  // reg1 = a_l * b_l, a no longer needed.
        ctrl.load_reg1 = 1'b1;
        ctrl.sel_reg1  = 1'b1;
      end
      SUM_B: begin
        ctrl.alu_a_sel = HALF_B;
        ctrl.alu_b_sel = HALF_B;
        ctrl.load_reg2 = 1'b1;
        ctrl.sel_reg2  = 1'b1;
      end
      MUL_MID: begin
        ctrl.mult_x_sel = STORED_SUM;
        ctrl.mult_y_sel = STORED_SUM;
        ctrl.load_reg4  = 1'b1;
      end
      SUB_HI: begin  // reg4 = mid - hi.
        ctrl.alu_a_sel = WIDE;
        ctrl.alu_b_sel = ACC;
        ctrl.sub       = 1'b1;
        ctrl.load_reg4 = 1'b1;
        ctrl.sel_reg4  = 1'b1;
      end
      SUB_LO: begin
        // middle term lands in reg2.
        ctrl.alu_a_sel      = WIDE;
        ctrl.alu_b_sel      = WIDE;
        ctrl.alu_b_wide_sel = 1'b0;
        ctrl.sub            = 1'b1;
        ctrl.load_reg2      = 1'b1;
        ctrl.sel_reg2       = 1'b1;
      end
      ADD_HI: begin  // reg3 = (hi << 5) + middle.
        ctrl.alu_a_sel      = ACC;
        ctrl.shamt          = BY_HALF;
        ctrl.alu_b_sel      = WIDE;
        ctrl.alu_b_wide_sel = 1'b1;
        ctrl.load_reg3      = 1'b1;
        ctrl.sel_reg3       = 1'b1;
      end
      ADD_MID: begin  // reg3 = (reg3 << 5) + lo.
        ctrl.alu_a_sel = ACC;
        ctrl.shamt     = BY_HALF;
        ctrl.alu_b_sel = WIDE;
        ctrl.load_reg3 = 1'b1;
        ctrl.sel_reg3  = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

// File: logic/karatsuba_dp.sv
`include "karatsuba_settings.svh"

module karatsuba_dp
  import karatsuba_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [`KM_OP_W-1:0]   a_i,
  input  logic [`KM_OP_W-1:0]   b_i,
  karatsuba_ctrl_if.dp          ctrl,
  output logic [`KM_PROD_W-1:0] product_o
);

  localparam int LutProdW = 2 * `KM_LUT_W;
  localparam int H        = `KM_HALF_W;

  logic [LutProdW-1:0]   reg1_q;
  logic [`KM_PROD_W-1:0] reg2_q;
  logic [`KM_PROD_W-1:0] reg3_q;
  logic [LutProdW-1:0]   reg4_q;

  logic [`KM_PROD_W-1:0] adder_sum;
  logic [LutProdW-1:0]   lut_prod;
  logic [`KM_PROD_W-1:0] reg3_sh;
  logic [`KM_PROD_W-1:0] alu_a;
  logic [`KM_PROD_W-1:0] alu_b;
  logic [`KM_PROD_W-1:0] alu_b_wide;
  km_lut_addr_u          lut_addr;

  // --------------------------------------------------
  // working registers
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (ctrl.load_reg1) begin
      reg1_q <= ctrl.sel_reg1 ? lut_prod : LutProdW'(a_i);
    end
    if (ctrl.load_reg2) begin
      reg2_q <= ctrl.sel_reg2 ? adder_sum : `KM_PROD_W'(b_i);
    end
    if (ctrl.load_reg4) begin
      reg4_q <= ctrl.sel_reg4 ? adder_sum[LutProdW-1:0] : lut_prod;
    end
  end

  // accumulator, also the visible product.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reg3_q <= '0;
    end else if (ctrl.load_reg3) begin
      reg3_q <= ctrl.sel_reg3 ? adder_sum : `KM_PROD_W'(lut_prod);
    end
  end

  assign product_o = reg3_q;

  always_comb begin
    case (ctrl.shamt)
      BY_HALF: reg3_sh = reg3_q << H;
      BY_FULL: reg3_sh = reg3_q << (2 * H);
      default: reg3_sh = reg3_q;
    endcase
  end

  // --------------------------------------------------
  // alu operands
  // --------------------------------------------------
  assign alu_b_wide = ctrl.alu_b_wide_sel ? reg2_q : `KM_PROD_W'(reg1_q);

  always_comb begin
    case (ctrl.alu_a_sel)
      HALF_A:  alu_a = `KM_PROD_W'(reg1_q[2*H-1:H]);  // upper halves.
      HALF_B:  alu_a = `KM_PROD_W'(reg2_q[2*H-1:H]);
      ACC:     alu_a = reg3_sh;
      default: alu_a = `KM_PROD_W'(reg4_q);
    endcase
  end

  always_comb begin
    case (ctrl.alu_b_sel)
      HALF_A:  alu_b = `KM_PROD_W'(reg1_q[H-1:0]);  // lower halves.
      HALF_B:  alu_b = `KM_PROD_W'(reg2_q[H-1:0]);
      ACC:     alu_b = reg3_sh;
      default: alu_b = alu_b_wide;
    endcase
  end

  cla_adder u_adder (
    .a_i     (alu_a),
    .b_i     (alu_b),
    .sub_i   (ctrl.sub),
    .sum_o   (adder_sum),
    .carry_o ()
  );

  // --------------------------------------------------
  // lookup address
  // --------------------------------------------------
  always_comb begin
    case (ctrl.mult_x_sel)
      HI_HALF:    lut_addr.f.x = `KM_LUT_W'(reg1_q[2*H-1:H]);
      STORED_SUM: lut_addr.f.x = reg4_q[`KM_LUT_W-1:0];  // half-sum of a.
      default:    lut_addr.f.x = `KM_LUT_W'(reg1_q[H-1:0]);
    endcase
    case (ctrl.mult_y_sel)
      HI_HALF:    lut_addr.f.y = `KM_LUT_W'(reg2_q[2*H-1:H]);
      STORED_SUM: lut_addr.f.y = reg2_q[`KM_LUT_W-1:0];  // half-sum of b.
      default:    lut_addr.f.y = `KM_LUT_W'(reg2_q[H-1:0]);
    endcase
  end

  mult_lut u_lut (
    .addr_i (lut_addr),
    .prod_o (lut_prod)
  );

endmodule

// File: logic/cla_adder.sv
`include "karatsuba_settings.svh"

module cla_adder (
  input  logic [`KM_PROD_W-1:0] a_i,
  input  logic [`KM_PROD_W-1:0] b_i,
  input  logic                  sub_i,
  output logic [`KM_PROD_W-1:0] sum_o,
  output logic                  carry_o
);

  localparam int NumGroups = `KM_PROD_W / 4;

  logic [`KM_PROD_W-1:0] b_eff;
  logic [`KM_PROD_W-1:0] p;
  logic [`KM_PROD_W-1:0] g;
  logic [`KM_PROD_W:0]   c;
  logic [NumGroups-1:0]  grp_p;
  logic [NumGroups-1:0]  grp_g;

  // two's complement subtract.
  assign b_eff = b_i ^ {`KM_PROD_W{sub_i}};
  assign p     = a_i ^ b_eff;
  assign g     = a_i & b_eff;
  assign c[0]  = sub_i;

  // --------------------------------------------------
  // 4-bit lookahead groups
  // --------------------------------------------------
  for (genvar k = 0; k < NumGroups; k++) begin : g_grp
    localparam int B = 4 * k;

    assign c[B+1] = g[B] | (p[B] & c[B]);
    assign c[B+2] = g[B+1] | (p[B+1] & g[B]) | (p[B+1] & p[B] & c[B]);
    assign c[B+3] = g[B+2] | (p[B+2] & g[B+1]) | (p[B+2] & p[B+1] & g[B])
                  | (p[B+2] & p[B+1] & p[B] & c[B]);

    assign grp_p[k] = &p[B+3:B];
    assign grp_g[k] = g[B+3] | (p[B+3] & g[B+2]) | (p[B+3] & p[B+2] & g[B+1])
                    | (p[B+3] & p[B+2] & p[B+1] & g[B]);

    // carry into the next group.
    assign c[B+4] = grp_g[k] | (grp_p[k] & c[B]);
  end

  assign sum_o   = p ^ c[`KM_PROD_W-1:0];
  assign carry_o = c[`KM_PROD_W];

endmodule

// File: logic/mult_lut.sv
`include "karatsuba_settings.svh"

module mult_lut
  import karatsuba_pkg::*;
(
  input  km_lut_addr_u              addr_i,
  output logic [2*`KM_LUT_W-1:0]    prod_o
);

  localparam int Depth = 1 << $bits(addr_i.index);
  localparam int ProdW = 2 * `KM_LUT_W;

  // full 64 x 64 table, one entry per index.
  always_comb begin
    km_lut_addr_u key;
    prod_o = '0;
    for (int i = 0; i < Depth; i++) begin
      key = km_lut_addr_u'(i);
      if (addr_i.index == key.index) begin
        prod_o = ProdW'(key.f.x) * ProdW'(key.f.y);  // fits in 12 bits.
      end
    end
  end

endmodule

// File: logic/karatsuba_ctrl_if.sv
interface karatsuba_ctrl_if import karatsuba_pkg::*; ();

  logic         load_reg1;
  logic         load_reg2;
  logic         load_reg3;
  logic         load_reg4;
  logic         sel_reg1;  // 0 operand, 1 lookup.
  logic         sel_reg2;  // 0 operand, 1 adder.
  logic         sel_reg3;  // 0 lookup, 1 adder.
  logic         sel_reg4;  // 0 lookup, 1 adder.
  km_alu_src_e  alu_a_sel;
  km_alu_src_e  alu_b_sel;
  logic         alu_b_wide_sel;  // 0 reg1, 1 reg2.
  km_mult_src_e mult_x_sel;
  km_mult_src_e mult_y_sel;
  km_shift_e    shamt;
  logic         sub;

  modport ctrl (
    output load_reg1, load_reg2, load_reg3, load_reg4,
    output sel_reg1, sel_reg2, sel_reg3, sel_reg4,
    output alu_a_sel, alu_b_sel, alu_b_wide_sel,
    output mult_x_sel, mult_y_sel,
    output shamt, sub
  );

  modport dp (
    input load_reg1, load_reg2, load_reg3, load_reg4,
    input sel_reg1, sel_reg2, sel_reg3, sel_reg4,
    input alu_a_sel, alu_b_sel, alu_b_wide_sel,
    input mult_x_sel, mult_y_sel,
    input shamt, sub
  );

endinterface

// File: logic/karatsuba_pkg.sv
`include "karatsuba_settings.svh"

package karatsuba_pkg;

  // controller steps, one per cycle.
  typedef enum logic [3:0] {
    IDLE, LOAD,
    MUL_LO, MUL_HI,
    SUM_A, SUM_B, MUL_MID,
    SUB_HI, SUB_LO,
    ADD_HI, ADD_MID,
    FINISH
  } km_step_e;

  typedef enum logic [1:0] {HALF_A, HALF_B, ACC, WIDE} km_alu_src_e;

  // lookup operand sources.
  typedef enum logic [1:0] {LO_HALF, HI_HALF, STORED_SUM} km_mult_src_e;

  typedef enum logic [1:0] {NONE, BY_HALF, BY_FULL} km_shift_e;

  typedef struct packed {
    logic [`KM_LUT_W-1:0] x;
    logic [`KM_LUT_W-1:0] y;
  } km_lut_ops_t;

  // same word seen as table index or as the two operands.
  typedef union packed {
    logic [2*`KM_LUT_W-1:0] index;
    km_lut_ops_t            f;
  } km_lut_addr_u;

endpackage

// File: logic/karatsuba_settings.svh
`ifndef KARATSUBA_SETTINGS_SVH
`define KARATSUBA_SETTINGS_SVH

// operand width.
`define KM_OP_W 10

// one half of an operand.
`define KM_HALF_W 5

// lookup operand, holds a sum of two halves.
`define KM_LUT_W 6

// product and adder width.
`define KM_PROD_W 20

`endif
